// File: dv/cpu_testdata.txt
# I <addr> <word>       program word at a byte address (hex)
# E <pc> <reg> <data>   expected trace record in program order (hex)
I bfc00000 24010005
I bfc00004 2402fffd
I bfc00008 34038001
I bfc0000c 3c041234
I bfc00010 3484abcd
I bfc00014 00222821
I bfc00018 00a13023
I bfc0001c 00833824
I bfc00020 00c74025
I bfc00024 01044826
I bfc00028 0041502a
I bfc0002c 0022582a
I bfc00030 00000000
I bfc00034 24200007
I bfc00038 00016021
I bfc0003c 00a60025
I bfc00040 000c6823
I bfc00044 25ae0010
I bfc00048 00000000
I bfc0004c 01cd7821
I bfc00050 01ee802a
I bfc00054 24218000
I bfc00058 3431ffff
I bfc0005c 3c128000
I bfc00060 0251982a
I bfc00064 0251a023
I bfc00068 0293a824
E bfc00000 01 00000005
E bfc00004 02 fffffffd
E bfc00008 03 00008001
E bfc0000c 04 12340000
E bfc00010 04 1234abcd
E bfc00014 05 00000002
E bfc00018 06 fffffffd
E bfc0001c 07 00008001
E bfc00020 08 fffffffd
E bfc00024 09 edcb5430
E bfc00028 0a 00000001
E bfc0002c 0b 00000000
E bfc00038 0c 00000005
E bfc00040 0d fffffffb
E bfc00044 0e 0000000b
E bfc0004c 0f 00000006
E bfc00050 10 00000001
E bfc00054 01 ffff8005
E bfc00058 11 ffffffff
E bfc0005c 12 80000000
E bfc00060 13 00000001
E bfc00064 14 80000001
E bfc00068 15 00000001

// File: dv/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic aclk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        aclk = 1'b0;
        forever begin
            #50 aclk = ~aclk;
        end
    end

    // reset held for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/100ps

module tb_top;

    localparam int imem_words = 256;
    localparam int pad_words  = 8;

    // first fetch address after reset
    localparam logic [31:0] reset_addr = 32'hbfc0_0000;

    logic        aclk;
    logic        rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // program image, word index relative to the reset pc
    logic [31:0] imem [0:imem_words-1];

    // expected trace records in program order
    logic [31:0] exp_pc   [$];
    logic [4:0]  exp_num  [$];
    logic [31:0] exp_data [$];

    // inst_addr seen in each cycle
    logic [31:0] addr_log [$];

    int          n_inst  = 0;
    int          max_idx = -1;
    int          rec_idx = 0;
    bit          loaded  = 1'b0;
    bit          done    = 1'b0;
    logic [31:0] rnd;

    tb_clock u_tb_clock (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    mycpu_top dut0 (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = (addr - reset_addr) >> 2;
        if (off < imem_words) begin
            return imem[off];
        end
        return 32'h0000_0000;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic read_data_file();
        int          fd;
        int          n;
        int          idx;
        string       line;
        string       rest;
        byte         kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = 32'h0000_0000;
        end
        fd = $fopen("dv/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the data file dv/cpu_testdata.txt");
            $display("test failed");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2) begin
                continue;
            end
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            if (kind == "I") begin
                n   = $sscanf(rest, "%h %h", a, b);
                idx = (a - reset_addr) >> 2;
                if (n != 2 || idx < 0 || idx >= imem_words - pad_words) begin
                    $display("bad instruction line in data file: %s", line);
                    $display("test failed");
                    $fatal(1, "bad data file");
                end
                imem[idx] = b;
                n_inst++;
                if (idx > max_idx) begin
                    max_idx = idx;
                end
            end else if (kind == "E") begin
                n = $sscanf(rest, "%h %h %h", a, b, c);
                if (n != 3) begin
                    $display("bad expect line in data file: %s", line);
                    $display("test failed");
                    $fatal(1, "bad data file");
                end
                exp_pc.push_back(a);
                exp_num.push_back(b[4:0]);
                exp_data.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // opcode and funct stay zero, so the padding never writes
    task automatic fill_padding(input logic [31:0] bits);
        logic [31:0] fields;
        for (int k = 0; k < pad_words; k++) begin
            fields             = bits >> k;
            imem[max_idx + 1 + k] = {6'd0, fields[14:0], 5'd0, 6'd0};
        end
    endtask

    task automatic check_record(input int cyc);
        if (rec_idx >= exp_pc.size()) begin
            $display("trace shows a write that no expected record accounts for, pc %h",
                     debug_wb_pc);
            $display("test failed");
            $fatal(1, "extra trace record");
        end
        if (cyc < 3) begin
            $display("trace record at cycle %0d, earlier than any fetch could finish", cyc);
            $display("test failed");
            $fatal(1, "early trace record");
        end
        check_value("wen byte lanes", 32'hf, {28'd0, debug_wb_rf_wen});
        if (rec_idx == 0) begin
            check_value("first record pc", reset_addr, debug_wb_pc);
        end
        check_value($sformatf("record %0d pc", rec_idx), exp_pc[rec_idx], debug_wb_pc);
        check_value($sformatf("record %0d wnum", rec_idx),
                    {27'd0, exp_num[rec_idx]}, {27'd0, debug_wb_rf_wnum});
        check_value($sformatf("record %0d wdata", rec_idx),
                    exp_data[rec_idx], debug_wb_rf_wdata);
        // pc must have been fetched exactly three cycles back
        check_value($sformatf("record %0d latency", rec_idx), addr_log[cyc - 3], debug_wb_pc);
        rec_idx++;
        if (rec_idx == exp_pc.size()) begin
            done = 1'b1;
        end
    endtask

    // instruction memory with a one-cycle read
    always @(posedge aclk) begin
        inst_rdata <= fetch_word(inst_addr);
    end

    // trace checker, sampled mid-cycle
    always @(negedge aclk) begin
        int cyc;
        addr_log.push_back(inst_addr);
        cyc = addr_log.size() - 1;
        if (!rst_n) begin
            check_value("wen during reset", 32'h0, {28'd0, debug_wb_rf_wen});
        end else if (debug_wb_rf_wen != 4'h0 && !done) begin
            check_record(cyc);
        end
    end

    initial begin
        inst_rdata = 32'h0000_0000;
        read_data_file();
        rnd = $urandom(71);
        fill_padding(rnd);
        $display("loaded %0d instructions and %0d expected records",
                 n_inst, exp_pc.size());
        loaded = 1'b1;
        wait (done);
        $display("test passed");
        $finish;
    end

    // reset, four cycles per instruction, some margin
    initial begin
        int limit;
        wait (loaded);
        limit = 3 + 4 * n_inst + 20;
        repeat (limit) @(posedge aclk);
        $display("watchdog: trace ended early, %0d of %0d records seen in %0d cycles",
                 rec_idx, exp_pc.size(), limit);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // datapath and register number widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // first fetch after reset
    localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;

    // major opcodes
    localparam logic [5:0] op_special = 6'd0;
    localparam logic [5:0] op_addiu   = 6'd9;
    localparam logic [5:0] op_ori     = 6'd13;
    localparam logic [5:0] op_lui     = 6'd15;

    // function codes under op_special
    localparam logic [5:0] fn_addu = 6'd33;
    localparam logic [5:0] fn_subu = 6'd35;
    localparam logic [5:0] fn_and  = 6'd36;
    localparam logic [5:0] fn_or   = 6'd37;
    localparam logic [5:0] fn_xor  = 6'd38;
    localparam logic [5:0] fn_slt  = 6'd42;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

endpackage

// File: hdl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           fs_valid,
    input  logic [cpu_pkg::xlen-1:0]       fs_pc,
    input  logic [cpu_pkg::xlen-1:0]       inst_rdata,
    input  logic                           exe_fwd_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] exe_fwd_dest,
    input  logic [cpu_pkg::xlen-1:0]       exe_fwd_data,
    input  logic                           rf_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    input  logic [cpu_pkg::xlen-1:0]       rf_wdata,
    output logic                           es_valid,
    output logic [cpu_pkg::xlen-1:0]       es_pc,
    output cpu_pkg::alu_op_t               es_alu_op,
    output logic [cpu_pkg::xlen-1:0]       es_src1,
    output logic [cpu_pkg::xlen-1:0]       es_src2,
    output logic [cpu_pkg::reg_addr_w-1:0] es_dest,
    output logic                           es_we
);

    cpu_pkg::inst_u                 inst;
    cpu_pkg::alu_op_t               alu_op;
    logic                           is_r;
    logic                           known;
    logic                           use_imm;
    logic [cpu_pkg::reg_addr_w-1:0] rs;
    logic [cpu_pkg::reg_addr_w-1:0] rt;
    logic [cpu_pkg::reg_addr_w-1:0] dest;
    logic [cpu_pkg::xlen-1:0]       imm_ext;
    logic [cpu_pkg::xlen-1:0]       rf_rdata1;
    logic [cpu_pkg::xlen-1:0]       rf_rdata2;
    logic [cpu_pkg::xlen-1:0]       opnd1;
    logic [cpu_pkg::xlen-1:0]       opnd2;

    assign inst = inst_rdata;
    assign is_r = (inst.r.opcode == cpu_pkg::op_special);
    // rs sits in the same bits in both formats
    assign rs   = inst.r.rs;
    // rt is only a source for R-type
    assign rt   = inst.r.rt;

    always_comb begin
        alu_op  = cpu_pkg::alu_add;
        known   = 1'b0;
        use_imm = 1'b0;
        dest    = '0;
        imm_ext = '0;
        if (is_r) begin
            dest  = inst.r.rd;
            known = 1'b1;
            case (inst.r.funct)
                cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                // includes the all-zero nop
                default:          known  = 1'b0;
            endcase
        end else begin
            dest    = inst.i.rt;
            known   = 1'b1;
            use_imm = 1'b1;
            case (inst.i.opcode)
                cpu_pkg::op_addiu: begin
                    alu_op  = cpu_pkg::alu_add;
                    imm_ext = {{16{inst.i.imm[15]}}, inst.i.imm};
                end
                cpu_pkg::op_ori: begin
                    alu_op  = cpu_pkg::alu_or;
                    imm_ext = {16'h0000, inst.i.imm};
                end
                cpu_pkg::op_lui: begin
                    alu_op  = cpu_pkg::alu_lui;
                    imm_ext = {inst.i.imm, 16'h0000};
                end
                default: known = 1'b0;
            endcase
        end
    end

    reg_file u_reg_file (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // youngest producer wins
    always_comb begin
        if (exe_fwd_we && exe_fwd_dest == rs) begin
            opnd1 = exe_fwd_data;
        end else if (rf_we && rf_waddr == rs) begin
            opnd1 = rf_wdata;
        end else begin
            opnd1 = rf_rdata1;
        end
    end

    always_comb begin
        if (exe_fwd_we && exe_fwd_dest == rt) begin
            opnd2 = exe_fwd_data;
        end else if (rf_we && rf_waddr == rt) begin
            opnd2 = rf_wdata;
        end else begin
            opnd2 = rf_rdata2;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
            es_we    <= 1'b0;
        end else begin
            es_valid <= fs_valid;
            // writes to $zero are dropped here for good
            es_we    <= known && (dest != '0);
        end
    end

    always_ff @(posedge aclk) begin
        es_pc     <= fs_pc;
        es_alu_op <= alu_op;
        es_src1   <= opnd1;
        es_src2   <= use_imm ? imm_ext : opnd2;
        es_dest   <= dest;
    end

endmodule

// File: hdl/exe_stage.sv
`timescale 1ns/100ps

module exe_stage (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           es_valid,
    input  logic [cpu_pkg::xlen-1:0]       es_pc,
    input  cpu_pkg::alu_op_t               es_alu_op,
    input  logic [cpu_pkg::xlen-1:0]       es_src1,
    input  logic [cpu_pkg::xlen-1:0]       es_src2,
    input  logic [cpu_pkg::reg_addr_w-1:0] es_dest,
    input  logic                           es_we,
    output logic                           exe_fwd_we,
    output logic [cpu_pkg::reg_addr_w-1:0] exe_fwd_dest,
    output logic [cpu_pkg::xlen-1:0]       exe_fwd_data,
    output logic                           ws_valid,
    output logic [cpu_pkg::xlen-1:0]       ws_pc,
    output logic [cpu_pkg::reg_addr_w-1:0] ws_dest,
    output logic                           ws_we,
    output logic [cpu_pkg::xlen-1:0]       ws_result
);

    logic [cpu_pkg::xlen-1:0] alu_result;

    always_comb begin
        case (es_alu_op)
            cpu_pkg::alu_add: alu_result = es_src1 + es_src2;
            cpu_pkg::alu_sub: alu_result = es_src1 - es_src2;
            cpu_pkg::alu_and: alu_result = es_src1 & es_src2;
            cpu_pkg::alu_or:  alu_result = es_src1 | es_src2;
            cpu_pkg::alu_xor: alu_result = es_src1 ^ es_src2;
            // signed compare
            cpu_pkg::alu_slt: alu_result = {31'd0, $signed(es_src1) < $signed(es_src2)};
            // decode already shifted the immediate up
            cpu_pkg::alu_lui: alu_result = es_src2;
            default:          alu_result = '0;
        endcase
    end

    // distance-1 bypass back to decode
    assign exe_fwd_we   = es_valid && es_we;
    assign exe_fwd_dest = es_dest;
    assign exe_fwd_data = alu_result;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
            ws_we    <= 1'b0;
        end else begin
            ws_valid <= es_valid;
            ws_we    <= es_we;
        end
    end

    always_ff @(posedge aclk) begin
        ws_pc     <= es_pc;
        ws_dest   <= es_dest;
        ws_result <= alu_result;
    end

    // decode must only ever hand over a legal operation
    a_alu_op_legal: assert property (
        @(posedge aclk) disable iff (!rst_n)
        es_valid |-> es_alu_op inside {cpu_pkg::alu_add, cpu_pkg::alu_sub,
                                       cpu_pkg::alu_and, cpu_pkg::alu_or,
                                       cpu_pkg::alu_xor, cpu_pkg::alu_slt,
                                       cpu_pkg::alu_lui}
    ) else $error("illegal alu op %0d at pc %h", es_alu_op, es_pc);

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                     aclk,
    input  logic                     rst_n,
    output logic [cpu_pkg::xlen-1:0] inst_addr,
    output logic                     fs_valid,
    output logic [cpu_pkg::xlen-1:0] fs_pc
);

    logic [cpu_pkg::xlen-1:0] pc;

    // the memory samples the pc directly
    assign inst_addr = pc;

    // straight-line fetch, no redirects
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= cpu_pkg::reset_pc;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // word for this pc arrives one cycle later
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            fs_valid <= 1'b0;
        end else begin
            fs_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        fs_pc <= pc;
    end

    // instruction fetches stay word aligned
    a_inst_addr_aligned: assert property (
        @(posedge aclk) disable iff (!rst_n)
        inst_addr[1:0] == 2'b00
    ) else $error("fetch address not word aligned: %h", inst_addr);

endmodule

// File: hdl/mycpu_top.sv
`timescale 1ns/100ps

module mycpu_top (
    input  logic        aclk,
    input  logic        rst_n,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    // fetch to decode
    logic                           fs_valid;
    logic [cpu_pkg::xlen-1:0]       fs_pc;

    // decode to execute
    logic                           es_valid;
    logic [cpu_pkg::xlen-1:0]       es_pc;
    cpu_pkg::alu_op_t               es_alu_op;
    logic [cpu_pkg::xlen-1:0]       es_src1;
    logic [cpu_pkg::xlen-1:0]       es_src2;
    logic [cpu_pkg::reg_addr_w-1:0] es_dest;
    logic                           es_we;

    // execute to write-back
    logic                           ws_valid;
    logic [cpu_pkg::xlen-1:0]       ws_pc;
    logic [cpu_pkg::reg_addr_w-1:0] ws_dest;
    logic                           ws_we;
    logic [cpu_pkg::xlen-1:0]       ws_result;

    // bypass paths back into decode
    logic                           exe_fwd_we;
    logic [cpu_pkg::reg_addr_w-1:0] exe_fwd_dest;
    logic [cpu_pkg::xlen-1:0]       exe_fwd_data;
    logic                           rf_we;
    logic [cpu_pkg::reg_addr_w-1:0] rf_waddr;
    logic [cpu_pkg::xlen-1:0]       rf_wdata;

    fetch_stage u_fetch_stage (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .inst_addr (inst_addr),
        .fs_valid  (fs_valid),
        .fs_pc     (fs_pc)
    );

    decode_stage u_decode_stage (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .fs_valid     (fs_valid),
        .fs_pc        (fs_pc),
        .inst_rdata   (inst_rdata),
        .exe_fwd_we   (exe_fwd_we),
        .exe_fwd_dest (exe_fwd_dest),
        .exe_fwd_data (exe_fwd_data),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .es_alu_op    (es_alu_op),
        .es_src1      (es_src1),
        .es_src2      (es_src2),
        .es_dest      (es_dest),
        .es_we        (es_we)
    );

    exe_stage u_exe_stage (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .es_alu_op    (es_alu_op),
        .es_src1      (es_src1),
        .es_src2      (es_src2),
        .es_dest      (es_dest),
        .es_we        (es_we),
        .exe_fwd_we   (exe_fwd_we),
        .exe_fwd_dest (exe_fwd_dest),
        .exe_fwd_data (exe_fwd_data),
        .ws_valid     (ws_valid),
        .ws_pc        (ws_pc),
        .ws_dest      (ws_dest),
        .ws_we        (ws_we),
        .ws_result    (ws_result)
    );

    wb_stage u_wb_stage (
        .ws_valid          (ws_valid),
        .ws_pc             (ws_pc),
        .ws_dest           (ws_dest),
        .ws_we             (ws_we),
        .ws_result         (ws_result),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output logic [cpu_pkg::xlen-1:0]       rdata1,
    output logic [cpu_pkg::xlen-1:0]       rdata2,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata
);

    logic [cpu_pkg::xlen-1:0] regs [0:31];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic                           ws_valid,
    input  logic [cpu_pkg::xlen-1:0]       ws_pc,
    input  logic [cpu_pkg::reg_addr_w-1:0] ws_dest,
    input  logic                           ws_we,
    input  logic [cpu_pkg::xlen-1:0]       ws_result,
    output logic                           rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [cpu_pkg::xlen-1:0]       rf_wdata,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    // register write, also the distance-2 bypass
    assign rf_we    = ws_valid && ws_we;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    // trace port mirrors the register write
    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

    // decode filters $zero writes, so none reach the trace
    always_comb begin
        a_no_zero_write: assert final (debug_wb_rf_wen == 4'b0000 || debug_wb_rf_wnum != '0)
            else $error("trace write to register 0 at pc %h", debug_wb_pc);
    end

endmodule

// File: src.f
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/exe_stage.sv
hdl/wb_stage.sv
hdl/mycpu_top.sv
dv/tb_clock.sv
dv/tb_top.sv
